//--- logic/ctrl_stage_if.sv
// Control-stage instruction bundle
// Carries the registered op from the stage register to the LSU and SPR unit,
// and their done strobes and read data back

`timescale 1ns/1ps

interface ctrl_stage_if;

   logic                                 op_load;
   logic                                 op_store;
   logic                                 op_mfspr;
   logic                                 op_mtspr;
   logic [pipe_pkg::OPERAND_WIDTH-1:0]   lsu_adr;
   logic [pipe_pkg::OPERAND_WIDTH-1:0]   store_data;
   logic [pipe_pkg::OPERAND_WIDTH-1:0]   spr_adr;
   logic [pipe_pkg::OPERAND_WIDTH-1:0]   alu_result;

   logic                                 lsu_valid;
   logic                                 lsu_except_align;
   logic [pipe_pkg::OPERAND_WIDTH-1:0]   lsu_rdata;
   logic                                 spr_ack;
   logic [pipe_pkg::OPERAND_WIDTH-1:0]   spr_rdata;

   modport stage (output op_load, op_store, op_mfspr, op_mtspr, lsu_adr, store_data,
                  spr_adr, alu_result,
                  input lsu_valid, lsu_except_align, lsu_rdata, spr_ack, spr_rdata);

   modport lsu (input op_load, op_store, lsu_adr, store_data,
                output lsu_valid, lsu_except_align, lsu_rdata);

   modport spr (input op_mfspr, op_mtspr, spr_adr, store_data,
                output spr_ack, spr_rdata);

   modport ctrl (input op_load, op_store, op_mfspr, op_mtspr, lsu_valid,
                 lsu_except_align, spr_ack);

endinterface

//--- logic/exec_alu.sv
// Execute-stage ALU
// Single-cycle logic ops, add/sub and jal link address, plus a multiply
// that takes a fixed number of cycles

`timescale 1ns/1ps

module exec_alu (
   input  logic                               clk,
   input  logic                               rst,
   input  pipe_pkg::opcode_e                  op_i,
   input  logic [pipe_pkg::OPERAND_WIDTH-1:0] a_i,
   input  logic [pipe_pkg::OPERAND_WIDTH-1:0] b_i,
   input  logic [pipe_pkg::OPERAND_WIDTH-1:0] pc_i,
   input  logic                               start_i,
   output logic [pipe_pkg::OPERAND_WIDTH-1:0] result_o,
   output logic                               alu_valid_o
);

   logic [pipe_pkg::MUL_CNT_WIDTH-1:0] mul_cnt;
   logic [pipe_pkg::OPERAND_WIDTH-1:0] mul_prod;
   logic                               mul_run;

   assign mul_run = start_i & (op_i == pipe_pkg::OP_MUL);

   // the counter restarts whenever execute stops holding a multiply
   always_ff @(posedge clk) begin
      if (rst) begin
         mul_cnt <= '0;
      end else if (!mul_run) begin
         mul_cnt <= '0;
      end else if (mul_cnt != pipe_pkg::MUL_LAST) begin
         mul_cnt <= mul_cnt + 1'b1;
      end
   end

   // product lands on the last counting edge and is held until the op leaves
   always_ff @(posedge clk) begin
      if (mul_run && mul_cnt == pipe_pkg::MUL_LAST - 1'b1) begin
         mul_prod <= a_i * b_i;
      end
   end

   assign alu_valid_o = (mul_cnt == pipe_pkg::MUL_LAST);

   always_comb begin
      case (op_i)
         pipe_pkg::OP_SUB: result_o = a_i - b_i;
         pipe_pkg::OP_AND: result_o = a_i & b_i;
         pipe_pkg::OP_OR:  result_o = a_i | b_i;
         pipe_pkg::OP_XOR: result_o = a_i ^ b_i;
         pipe_pkg::OP_MUL: result_o = mul_prod;
         pipe_pkg::OP_JAL: result_o = pc_i + 32'd4;
         // add, and the effective address of memory and SPR ops
         default:          result_o = a_i + b_i;
      endcase
   end

endmodule

//--- logic/execute_ctrl_stage.sv
// Execute to control stage register
// Moves the op into the control stage on advance, tracks the pending
// register write and produces the ordered write-back port

`timescale 1ns/1ps

module execute_ctrl_stage (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               padv_i,
   input  logic                               flush_i,
   input  pipe_pkg::opcode_e                  op_i,
   input  logic [pipe_pkg::OPERAND_WIDTH-1:0] alu_result_i,
   input  logic [pipe_pkg::OPERAND_WIDTH-1:0] b_i,
   input  logic [pipe_pkg::OPERAND_WIDTH-1:0] adder_result_i,
   input  logic [pipe_pkg::RF_ADDR_WIDTH-1:0] rfd_adr_i,
   input  logic [pipe_pkg::OPERAND_WIDTH-1:0] pc_i,
   input  logic                               bubble_i,
   output logic [pipe_pkg::OPERAND_WIDTH-1:0] pc_ctrl_o,
   output pipe_pkg::opcode_e                  opc_ctrl_o,
   output logic                               wb_we_o,
   output logic [pipe_pkg::RF_ADDR_WIDTH-1:0] wb_adr_o,
   output logic [pipe_pkg::OPERAND_WIDTH-1:0] wb_data_o,
   ctrl_stage_if.stage                        ctrl_if
);

   logic                               exec_rf_wb;
   logic                               ctrl_rf_wb;
   logic                               ctrl_done;
   logic [pipe_pkg::RF_ADDR_WIDTH-1:0] ctrl_rfd_adr;
   logic [pipe_pkg::OPERAND_WIDTH-1:0] ctrl_adr;

   // everything except nop, stores and mtspr writes a register
   assign exec_rf_wb = !bubble_i && op_i != pipe_pkg::OP_NOP && op_i != pipe_pkg::OP_STORE &&
                       op_i != pipe_pkg::OP_MTSPR;

   // operands and addresses are payload and only follow the advance
   always_ff @(posedge clk) begin
      if (padv_i) begin
         ctrl_if.alu_result <= alu_result_i;
         ctrl_adr           <= adder_result_i;
         ctrl_if.store_data <= b_i;
         ctrl_rfd_adr       <= rfd_adr_i;
      end
   end

   assign ctrl_if.lsu_adr = ctrl_adr;
   assign ctrl_if.spr_adr = ctrl_adr;

   // a bubble moving into control must not disturb the faulting PC
   always_ff @(posedge clk) begin
      if (rst) begin
         pc_ctrl_o <= pipe_pkg::RESET_PC;
      end else if (padv_i && !bubble_i) begin
         pc_ctrl_o <= pc_i;
      end
   end

   // advance wins over flush so a younger op entering control survives
   always_ff @(posedge clk) begin
      if (rst) begin
         opc_ctrl_o <= pipe_pkg::OP_NOP;
      end else if (padv_i) begin
         opc_ctrl_o <= bubble_i ? pipe_pkg::OP_NOP : op_i;
      end else if (flush_i) begin
         opc_ctrl_o <= pipe_pkg::OP_NOP;
      end
   end

   assign ctrl_if.op_mfspr = (opc_ctrl_o == pipe_pkg::OP_MFSPR);
   assign ctrl_if.op_mtspr = (opc_ctrl_o == pipe_pkg::OP_MTSPR);

   // a misaligned access is killed in place so it cannot fault twice
   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_if.op_load  <= 1'b0;
         ctrl_if.op_store <= 1'b0;
      end else if (padv_i) begin
         ctrl_if.op_load  <= !bubble_i && op_i == pipe_pkg::OP_LOAD;
         ctrl_if.op_store <= !bubble_i && op_i == pipe_pkg::OP_STORE;
      end else if (ctrl_if.lsu_except_align || flush_i) begin
         ctrl_if.op_load  <= 1'b0;
         ctrl_if.op_store <= 1'b0;
      end
   end

   // loads and mfspr finish on their unit strobe, all other ops right away
   always_comb begin
      if (ctrl_if.op_load) begin
         ctrl_done = ctrl_if.lsu_valid;
      end else if (ctrl_if.op_mfspr) begin
         ctrl_done = ctrl_if.spr_ack;
      end else begin
         ctrl_done = 1'b1;
      end
   end

   // the pending write is dropped once it has been issued
   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_rf_wb <= 1'b0;
      end else if (padv_i) begin
         ctrl_rf_wb <= exec_rf_wb;
      end else if (ctrl_done || flush_i) begin
         ctrl_rf_wb <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wb_we_o <= 1'b0;
      end else begin
         wb_we_o <= ctrl_rf_wb && ctrl_done && !ctrl_if.lsu_except_align;
      end
   end

   always_ff @(posedge clk) begin
      wb_adr_o <= ctrl_rfd_adr;
      if (ctrl_if.op_load) begin
         wb_data_o <= ctrl_if.lsu_rdata;
      end else if (ctrl_if.op_mfspr) begin
         wb_data_o <= ctrl_if.spr_rdata;
      end else begin
         wb_data_o <= ctrl_if.alu_result;
      end
   end

endmodule

//--- logic/lsu_mem.sv
// Control-stage load/store unit
// Word-addressed local data memory with a fixed access latency and an
// alignment check that faults instead of accessing memory

`timescale 1ns/1ps

module lsu_mem (
   input  logic   clk,
   input  logic   rst,
   input  logic   padv_i,
   ctrl_stage_if.lsu ctrl_if
);

   logic [pipe_pkg::OPERAND_WIDTH-1:0] mem [pipe_pkg::MEM_WORDS];
   logic [pipe_pkg::LSU_CNT_WIDTH-1:0] cnt;
   logic [pipe_pkg::MEM_IDX_WIDTH-1:0] idx;
   logic                               access;
   logic                               misaligned;

   assign access     = ctrl_if.op_load | ctrl_if.op_store;
   assign misaligned = access && ctrl_if.lsu_adr[1:0] != 2'b00;
   assign idx        = ctrl_if.lsu_adr[pipe_pkg::MEM_IDX_WIDTH+1:2];

   // counts from entry and holds at the end until the next advance
   always_ff @(posedge clk) begin
      if (rst || padv_i) begin
         cnt <= '0;
      end else if (access && !misaligned && cnt != pipe_pkg::LSU_LAST) begin
         cnt <= cnt + 1'b1;
      end
   end

   // store commits exactly once, on the edge that completes the access
   always_ff @(posedge clk) begin
      if (ctrl_if.op_store && !misaligned && !padv_i &&
          cnt == pipe_pkg::LSU_LAST - 1'b1) begin
         mem[idx] <= ctrl_if.store_data;
      end
   end

   // memory contents start at zero so untouched words read back as zero
   initial begin
      for (int i = 0; i < pipe_pkg::MEM_WORDS; i++) begin
         mem[i] = '0;
      end
   end

   assign ctrl_if.lsu_valid        = misaligned || (access && cnt == pipe_pkg::LSU_LAST);
   assign ctrl_if.lsu_except_align = misaligned;
   assign ctrl_if.lsu_rdata        = mem[idx];

endmodule

//--- logic/pipe_backend.sv
// Processor back end top level
// Execute stage, stage register, control-stage units and pipeline control
// behind plain instruction and write-back ports

`timescale 1ns/1ps

module pipe_backend (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               insn_valid_i,
   input  pipe_pkg::opcode_e                  opcode_i,
   input  logic [pipe_pkg::OPERAND_WIDTH-1:0] operand_a_i,
   input  logic [pipe_pkg::OPERAND_WIDTH-1:0] operand_b_i,
   input  logic [pipe_pkg::RF_ADDR_WIDTH-1:0] rfd_adr_i,
   input  logic [pipe_pkg::OPERAND_WIDTH-1:0] pc_i,
   output logic                               execute_ready_o,
   output logic                               wb_we_o,
   output logic [pipe_pkg::RF_ADDR_WIDTH-1:0] wb_adr_o,
   output logic [pipe_pkg::OPERAND_WIDTH-1:0] wb_data_o,
   output logic                               except_o,
   output logic [pipe_pkg::OPERAND_WIDTH-1:0] except_pc_o
);

   logic                               padv;
   logic                               bubble;
   logic                               flush;
   logic                               alu_valid;
   logic [pipe_pkg::OPERAND_WIDTH-1:0] alu_result;
   logic [pipe_pkg::OPERAND_WIDTH-1:0] pc_ctrl;

   ctrl_stage_if ctrl_if ();

   assign execute_ready_o = padv;

   pipe_ctrl u_pipe_ctrl (
      .clk          (clk),
      .rst          (rst),
      .insn_valid_i (insn_valid_i),
      .op_i         (opcode_i),
      .alu_valid_i  (alu_valid),
      .pc_ctrl_i    (pc_ctrl),
      .padv_o       (padv),
      .bubble_o     (bubble),
      .flush_o      (flush),
      .except_o     (except_o),
      .except_pc_o  (except_pc_o),
      .ctrl_if      (ctrl_if.ctrl)
   );

   // the multiplier runs while a valid op is held in execute
   exec_alu u_exec_alu (
      .clk         (clk),
      .rst         (rst),
      .op_i        (opcode_i),
      .a_i         (operand_a_i),
      .b_i         (operand_b_i),
      .pc_i        (pc_i),
      .start_i     (insn_valid_i & ~padv),
      .result_o    (alu_result),
      .alu_valid_o (alu_valid)
   );

   execute_ctrl_stage u_execute_ctrl_stage (
      .clk            (clk),
      .rst            (rst),
      .padv_i         (padv),
      .flush_i        (flush),
      .op_i           (opcode_i),
      .alu_result_i   (alu_result),
      .b_i            (operand_b_i),
      .adder_result_i (alu_result),
      .rfd_adr_i      (rfd_adr_i),
      .pc_i           (pc_i),
      .bubble_i       (bubble),
      .pc_ctrl_o      (pc_ctrl),
      .opc_ctrl_o     (),
      .wb_we_o        (wb_we_o),
      .wb_adr_o       (wb_adr_o),
      .wb_data_o      (wb_data_o),
      .ctrl_if        (ctrl_if.stage)
   );

   lsu_mem u_lsu_mem (
      .clk     (clk),
      .rst     (rst),
      .padv_i  (padv),
      .ctrl_if (ctrl_if.lsu)
   );

   spr_unit u_spr_unit (
      .clk     (clk),
      .rst     (rst),
      .padv_i  (padv),
      .ctrl_if (ctrl_if.spr)
   );

endmodule

//--- logic/pipe_ctrl.sv
// Pipeline control
// Derives advance and stall from the unit done strobes, and turns an
// alignment fault into an exception pulse and a flush

`timescale 1ns/1ps

module pipe_ctrl (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               insn_valid_i,
   input  pipe_pkg::opcode_e                  op_i,
   input  logic                               alu_valid_i,
   input  logic [pipe_pkg::OPERAND_WIDTH-1:0] pc_ctrl_i,
   output logic                               padv_o,
   output logic                               bubble_o,
   output logic                               flush_o,
   output logic                               except_o,
   output logic [pipe_pkg::OPERAND_WIDTH-1:0] except_pc_o,
   ctrl_stage_if.ctrl                         ctrl_if
);

   logic waiting;

   // only the multiplier, the LSU and the SPR unit can hold the pipe
   assign waiting = (insn_valid_i && op_i == pipe_pkg::OP_MUL && !alu_valid_i) ||
                    ((ctrl_if.op_load || ctrl_if.op_store) && !ctrl_if.lsu_valid) ||
                    ((ctrl_if.op_mfspr || ctrl_if.op_mtspr) && !ctrl_if.spr_ack);

   // execute moves every cycle it is not held, pushing a bubble if empty
   assign padv_o   = !waiting;
   assign bubble_o = padv_o && !insn_valid_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         except_o <= 1'b0;
         flush_o  <= 1'b0;
      end else begin
         except_o <= ctrl_if.lsu_except_align;
         // nothing to flush when a younger op has already replaced the fault
         flush_o  <= ctrl_if.lsu_except_align && !padv_o;
      end
   end

   always_ff @(posedge clk) begin
      if (ctrl_if.lsu_except_align) begin
         except_pc_o <= pc_ctrl_i;
      end
   end

endmodule

//--- logic/pipe_pkg.sv
// Pipeline back end package
// Opcodes, widths, reset PC and sizes shared by the execute and control stages

package pipe_pkg;

   typedef enum logic [3:0] {
      OP_NOP   = 4'd0,
      OP_ADD   = 4'd1,
      OP_SUB   = 4'd2,
      OP_AND   = 4'd3,
      OP_OR    = 4'd4,
      OP_XOR   = 4'd5,
      OP_MUL   = 4'd6,
      OP_JAL   = 4'd7,
      OP_LOAD  = 4'd8,
      OP_STORE = 4'd9,
      OP_MFSPR = 4'd10,
      OP_MTSPR = 4'd11
   } opcode_e;

   localparam int OPERAND_WIDTH = 32;
   localparam int RF_ADDR_WIDTH = 5;

   localparam logic [OPERAND_WIDTH-1:0] RESET_PC = 32'h0000_0100;

   // data memory and special-purpose register file sizes
   localparam int MEM_WORDS     = 16;
   localparam int MEM_IDX_WIDTH = $clog2(MEM_WORDS);
   localparam int SPR_COUNT     = 4;
   localparam int SPR_IDX_WIDTH = $clog2(SPR_COUNT);

   // multi-cycle unit latencies and their counter terminal values
   localparam int MUL_CYCLES    = 3;
   localparam int MUL_CNT_WIDTH = $clog2(MUL_CYCLES + 1);
   localparam logic [MUL_CNT_WIDTH-1:0] MUL_LAST = MUL_CNT_WIDTH'(MUL_CYCLES);

   localparam int LSU_CYCLES    = 2;
   localparam int LSU_CNT_WIDTH = $clog2(LSU_CYCLES + 1);
   localparam logic [LSU_CNT_WIDTH-1:0] LSU_LAST = LSU_CNT_WIDTH'(LSU_CYCLES);

endpackage

//--- logic/spr_unit.sv
// Special-purpose register unit
// Four registers read by mfspr and written by mtspr, each access
// acknowledged one cycle after it enters the control stage

`timescale 1ns/1ps

module spr_unit (
   input  logic   clk,
   input  logic   rst,
   input  logic   padv_i,
   ctrl_stage_if.spr ctrl_if
);

   logic [pipe_pkg::OPERAND_WIDTH-1:0] spr [pipe_pkg::SPR_COUNT];
   logic [pipe_pkg::SPR_IDX_WIDTH-1:0] idx;
   logic                               access;
   logic                               ack;

   assign access = ctrl_if.op_mfspr | ctrl_if.op_mtspr;
   assign idx    = ctrl_if.spr_adr[pipe_pkg::SPR_IDX_WIDTH-1:0];

   // ack rises one edge after entry and stays until the op moves on
   always_ff @(posedge clk) begin
      if (rst) begin
         ack <= 1'b0;
      end else begin
         ack <= access && !padv_i;
      end
   end

   // the write lands on the edge that raises the acknowledge
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < pipe_pkg::SPR_COUNT; i++) begin
            spr[i] <= '0;
         end
      end else if (ctrl_if.op_mtspr && !padv_i && !ack) begin
         spr[idx] <= ctrl_if.store_data;
      end
   end

   assign ctrl_if.spr_ack   = ack;
   assign ctrl_if.spr_rdata = spr[idx];

endmodule

//--- pipe_backend.f
logic/pipe_pkg.sv
logic/ctrl_stage_if.sv
logic/exec_alu.sv
logic/execute_ctrl_stage.sv
logic/lsu_mem.sv
logic/spr_unit.sv
logic/pipe_ctrl.sv
logic/pipe_backend.sv
test/pipe_backend_assertions.sv
test/pipe_backend_tb.sv

//--- run.sh
#!/bin/sh
# builds the back end testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module pipe_backend_tb -f pipe_backend.f

output=$(./obj_dir/Vpipe_backend_tb +verilator+error+limit+1000)
echo "$output"

if echo "$output" | grep -q "TESTBENCH PASSED"; then
   exit 0
fi
exit 1

//--- test/pipe_backend_assertions.sv
// Control timing assertions for the processor back end
// Bound into the top level to watch reset, exception and advance behavior

`timescale 1ns/1ps

module pipe_backend_assertions (
   input logic              clk,
   input logic              rst,
   input logic              wb_we_i,
   input logic              except_i,
   input logic [31:0]       except_pc_i,
   input logic              padv_i,
   input logic              insn_valid_i,
   input pipe_pkg::opcode_e opcode_i
);

   // number of failed assertions so far
   int failures = 0;

   // cycles the multiply now in execute has been held there
   int mul_held;

   always_ff @(posedge clk) begin
      if (rst || padv_i) begin
         mul_held <= 0;
      end else if (insn_valid_i && opcode_i == pipe_pkg::OP_MUL) begin
         mul_held <= mul_held + 1;
      end
   end

   wb_quiet_in_reset: assert property (@(posedge clk) rst |=> !wb_we_i)
   else begin
      failures++;
      $error("wb_we_o high while in reset");
   end

   // back-to-back faults give back-to-back pulses, each with its own PC
   except_single_pulse: assert property (@(posedge clk) disable iff (rst)
      except_i |=> (!except_i || except_pc_i != $past(except_pc_i)))
   else begin
      failures++;
      $error("except_o held for more than one cycle for the same fault");
   end

   no_advance_mid_mul: assert property (@(posedge clk) disable iff (rst)
      (insn_valid_i && opcode_i == pipe_pkg::OP_MUL && padv_i) |->
         mul_held >= pipe_pkg::MUL_CYCLES)
   else begin
      failures++;
      $error("pipeline advanced before the multiply finished");
   end

endmodule

bind pipe_backend pipe_backend_assertions u_pipe_backend_assertions (
   .clk          (clk),
   .rst          (rst),
   .wb_we_i      (wb_we_o),
   .except_i     (except_o),
   .except_pc_i  (except_pc_o),
   .padv_i       (padv),
   .insn_valid_i (insn_valid_i),
   .opcode_i     (opcode_i)
);

//--- test/pipe_backend_tb.sv
// Testbench for the processor back end
// Drives a random instruction stream, predicts every write-back and exception
// with an in-order reference model and compares them at the output ports

`timescale 1ns/1ps

module pipe_backend_tb;

   localparam int NUM_RANDOM    = 300;
   localparam int READY_TIMEOUT = 50;
   localparam int DRAIN_TIMEOUT = 100;

   logic              clk;
   logic              rst;
   logic              insn_valid;
   pipe_pkg::opcode_e opcode;
   logic [31:0]       operand_a;
   logic [31:0]       operand_b;
   logic [4:0]        rfd_adr;
   logic [31:0]       pc;
   logic              execute_ready;
   logic              wb_we;
   logic [4:0]        wb_adr;
   logic [31:0]       wb_data;
   logic              except_flag;
   logic [31:0]       except_pc;

   // reference model state and the expected results in program order
   logic [31:0] model_mem [16];
   logic [31:0] model_spr [4];
   logic [4:0]  exp_adr_q [$];
   logic [31:0] exp_data_q [$];
   logic [31:0] exp_pc_q [$];
   int          checks;
   int          errors;
   int          timeouts;

   pipe_backend DUT (
      .clk             (clk),
      .rst             (rst),
      .insn_valid_i    (insn_valid),
      .opcode_i        (opcode),
      .operand_a_i     (operand_a),
      .operand_b_i     (operand_b),
      .rfd_adr_i       (rfd_adr),
      .pc_i            (pc),
      .execute_ready_o (execute_ready),
      .wb_we_o         (wb_we),
      .wb_adr_o        (wb_adr),
      .wb_data_o       (wb_data),
      .except_o        (except_flag),
      .except_pc_o     (except_pc)
   );

   always #20 clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
      end
   endtask

   task automatic finish_run();
      int assert_fails;
      assert_fails = DUT.u_pipe_backend_assertions.failures;
      $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
               checks, errors, assert_fails, timeouts);
      if (errors == 0 && assert_fails == 0 && timeouts == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   endtask

   // memory and SPR ops use a + b as their address and b as their data
   task automatic model_step(input pipe_pkg::opcode_e op, input logic [31:0] a,
                             input logic [31:0] b);
      logic [31:0] addr;
      logic [31:0] result;
      addr = a + b;
      case (op)
         pipe_pkg::OP_SUB:   result = a - b;
         pipe_pkg::OP_AND:   result = a & b;
         pipe_pkg::OP_OR:    result = a | b;
         pipe_pkg::OP_XOR:   result = a ^ b;
         pipe_pkg::OP_MUL:   result = a * b;
         pipe_pkg::OP_JAL:   result = pc + 32'd4;
         pipe_pkg::OP_LOAD:  result = model_mem[addr[5:2]];
         pipe_pkg::OP_MFSPR: result = model_spr[addr[1:0]];
         default:            result = addr;
      endcase
      if ((op == pipe_pkg::OP_LOAD || op == pipe_pkg::OP_STORE) && addr[1:0] != 2'b00) begin
         // a misaligned access faults and touches neither memory nor registers
         exp_pc_q.push_back(pc);
      end else if (op == pipe_pkg::OP_STORE) begin
         model_mem[addr[5:2]] = b;
      end else if (op == pipe_pkg::OP_MTSPR) begin
         model_spr[addr[1:0]] = b;
      end else if (op != pipe_pkg::OP_NOP) begin
         exp_adr_q.push_back(rfd_adr);
         exp_data_q.push_back(result);
      end
   endtask

   // called on a falling edge, returns on the falling edge after the advance
   task automatic issue(input pipe_pkg::opcode_e op, input logic [31:0] a,
                        input logic [31:0] b);
      int waited;
      waited     = 0;
      insn_valid = 1'b1;
      opcode     = op;
      operand_a  = a;
      operand_b  = b;
      rfd_adr    = 5'($urandom_range(0, 31));
      // ready only changes on rising edges, so mid low phase is a settled sample
      #10;
      while (!execute_ready && waited < READY_TIMEOUT) begin
         @(negedge clk);
         #10;
         waited++;
      end
      if (!execute_ready) begin
         timeouts++;
         $display("timeout: instruction at pc %h was never accepted", pc);
         finish_run();
      end else begin
         if (op == pipe_pkg::OP_MUL && waited < pipe_pkg::MUL_CYCLES) begin
            errors++;
            $display("multiply at pc %h accepted after only %0d stall cycles", pc, waited);
         end
         model_step(op, a, b);
         @(negedge clk);
         pc = pc + 32'd4;
      end
   endtask

   task automatic idle(input int cycles);
      insn_valid = 1'b0;
      opcode     = pipe_pkg::OP_NOP;
      repeat (cycles) @(negedge clk);
   endtask

   // word aligned inside the data memory, now and then off by a byte or two
   function automatic logic [31:0] pick_addr();
      logic [31:0] addr;
      addr = {26'd0, 4'($urandom_range(0, 15)), 2'b00};
      if ($urandom_range(0, 7) == 0) begin
         addr[1:0] = 2'($urandom_range(1, 3));
      end
      return addr;
   endfunction

   task automatic drain();
      int waited;
      waited = 0;
      while ((exp_adr_q.size() != 0 || exp_pc_q.size() != 0) && waited < DRAIN_TIMEOUT) begin
         @(negedge clk);
         #5;
         waited++;
      end
      if (exp_adr_q.size() != 0 || exp_pc_q.size() != 0) begin
         timeouts++;
         $display("drain timed out with %0d write-backs and %0d exceptions still missing",
                  exp_adr_q.size(), exp_pc_q.size());
      end
      // a few more cycles to catch stray pulses after the last expected one
      repeat (4) @(negedge clk);
   endtask

   always @(negedge clk) begin
      if (!rst && wb_we === 1'b1) begin
         if (exp_adr_q.size() == 0) begin
            errors++;
            $display("write-back to r%0d with no instruction expecting one", wb_adr);
         end else begin
            check_value("wb_adr_o", {27'd0, wb_adr}, {27'd0, exp_adr_q.pop_front()});
            check_value("wb_data_o", wb_data, exp_data_q.pop_front());
         end
      end
      if (!rst && except_flag === 1'b1) begin
         if (exp_pc_q.size() == 0) begin
            errors++;
            $display("exception at pc %h with no faulting instruction expected", except_pc);
         end else begin
            check_value("except_pc_o", except_pc, exp_pc_q.pop_front());
         end
      end
   end

   initial begin
      pipe_pkg::opcode_e op;
      logic [31:0]       data;
      logic [31:0]       target;
      void'($urandom(23673));
      clk        = 1'b0;
      rst        = 1'b1;
      insn_valid = 1'b0;
      opcode     = pipe_pkg::OP_NOP;
      operand_a  = '0;
      operand_b  = '0;
      rfd_adr    = '0;
      pc         = 32'h0000_1000;
      checks     = 0;
      errors     = 0;
      timeouts   = 0;
      for (int i = 0; i < 16; i++) begin
         model_mem[i] = '0;
      end
      for (int i = 0; i < 4; i++) begin
         model_spr[i] = '0;
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // untouched word, store then load, misaligned store and load, SPR round trip
      issue(pipe_pkg::OP_LOAD, 32'd20, 32'd0);
      issue(pipe_pkg::OP_STORE, 32'd12 - 32'hcafe_f00d, 32'hcafe_f00d);
      issue(pipe_pkg::OP_LOAD, 32'd12, 32'd0);
      issue(pipe_pkg::OP_STORE, 32'd29 - 32'h1234_5678, 32'h1234_5678);
      issue(pipe_pkg::OP_LOAD, 32'd28, 32'd0);
      issue(pipe_pkg::OP_LOAD, 32'd30, 32'd0);
      issue(pipe_pkg::OP_MTSPR, 32'd2 - 32'h0bad_beef, 32'h0bad_beef);
      issue(pipe_pkg::OP_MFSPR, 32'd2, 32'd0);
      issue(pipe_pkg::OP_MUL, 32'd7, 32'd9);
      issue(pipe_pkg::OP_JAL, 32'd0, 32'd0);

      for (int i = 0; i < NUM_RANDOM; i++) begin
         op   = pipe_pkg::opcode_e'(4'($urandom_range(0, 11)));
         data = $urandom();
         if (op == pipe_pkg::OP_LOAD || op == pipe_pkg::OP_STORE) begin
            target = pick_addr();
         end else if (op == pipe_pkg::OP_MFSPR || op == pipe_pkg::OP_MTSPR) begin
            target = $urandom_range(0, 3);
         end else begin
            target = $urandom();
         end
         issue(op, target - data, data);
         if ($urandom_range(0, 7) == 0) begin
            idle($urandom_range(1, 3));
         end
      end

      idle(1);
      drain();
      finish_run();
   end

endmodule
